/* Makefile */
# Verilator build and run of the fetch and redirect testbench

VERILATOR ?= verilator
TOP       ?= fetch_predict_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

# the run passes only if the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
+incdir+hdl
hdl/fetch_pkg.sv
hdl/btb.sv
hdl/redirect_control.sv
hdl/program_counter.sv
hdl/fetch_latch.sv
hdl/fetch_predict.sv
test/fetch_predict_asserts.sv
test/fetch_predict_tb.sv

/* hdl/btb.sv */
// branch target buffer
// direct mapped, one entry per index, each with tag, target and
// a 2-bit predictor state
// two combinational read ports: fetch side lookup and resolve side check
// a write replaces the whole entry at update.idx

`default_nettype none

module btb
   import fetch_pkg::*;
(
   input  logic        CLK,
   input  logic        nRST,
   input  word_t       fetch_pc,
   input  word_t       resolve_pc,
   input  btb_update_t update,
   output btb_entry_t  lookup,
   output btb_entry_t  check
);

   // depth follows index width
   btb_entry_t entries [2**$bits(btb_idx_t)];

   btb_idx_t fetch_idx;
   btb_idx_t resolve_idx;
   btb_entry_t wr_entry;

   assign fetch_idx   = btb_idx_of(fetch_pc);
   assign resolve_idx = btb_idx_of(resolve_pc);

   // read ports, no tag compare here
   assign lookup = entries[fetch_idx];   // prediction at fetch
   assign check  = entries[resolve_idx]; // state of the resolving branch

   // whole entry is rewritten, always valid after a write
   assign wr_entry.valid  = 1'b1;
   assign wr_entry.tag    = update.tag;
   assign wr_entry.target = update.target;
   assign wr_entry.state  = update.state;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         for (int i = 0; i < $size(entries); i++)
         begin
            entries[i] <= '0; // all invalid
         end
      end
      else if (update.write)
      begin
         entries[update.idx] <= wr_entry; // alloc, realloc on alias, or train
      end
   end

endmodule

`default_nettype wire

/* hdl/fetch_latch.sv */
// fetch/decode pipeline register
// flush clears it to a bubble, ihit captures the fetched word,
// otherwise it holds

`default_nettype none

module fetch_latch
   import fetch_pkg::*;
(
   input  logic   CLK,
   input  logic   nRST,
   input  logic   ihit,
   input  logic   flush,
   input  word_t  instr,
   input  word_t  pc_plus_4,
   input  logic   predict,
   output fetch_t fetch_out
);

   fetch_t fetch_in;

   assign fetch_in.instr     = instr;
   assign fetch_in.pc_plus_4 = pc_plus_4;
   assign fetch_in.predicted = predict; // travels with the instr to resolve

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         fetch_out <= '0;
      end
      else if (flush)
      begin
         fetch_out <= '0;        // squash wrong path fetch
      end
      else if (ihit)
      begin
         fetch_out <= fetch_in;
      end
   end

endmodule

`default_nettype wire

/* hdl/fetch_pkg.sv */
// fetch slice types
// word, BTB index and tag vectors, 2-bit predictor states,
// BTB entry, resolve bundle, fetch/decode register and BTB write command
// also the index/tag split of an address, used by BTB and control alike

`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

   typedef logic [`FETCH_WORD_W-1:0] word_t;
   typedef logic [`FETCH_BTB_IDX_W-1:0] btb_idx_t;                  // addr bits 3:2
   typedef logic [`FETCH_WORD_W-`FETCH_BTB_IDX_W-3:0] btb_tag_t;    // addr bits 31:4

   // 2-bit saturating counter, msb low means taken half
   typedef enum logic [1:0] {
      STRONG_TAKEN = 2'b00,
      WEAK_TAKEN   = 2'b01,
      WEAK_NOT     = 2'b10,
      STRONG_NOT   = 2'b11
   } pred_state_t;

   typedef struct packed {
      logic        valid;
      btb_tag_t    tag;
      word_t       target;    // predicted taken address
      pred_state_t state;
   } btb_entry_t;

   // one resolved branch or jump from the resolving stage
   typedef struct packed {
      logic  valid;      // one cycle strobe
      logic  cond;       // conditional branch
      logic  jump;       // j, jal, jr
      logic  taken;      // actual outcome of cond
      logic  predicted;  // prediction bit carried from fetch
      word_t pc;         // branch's own address
      word_t target;     // resolved taken / jump address
   } resolve_t;

   typedef struct packed {
      word_t instr;
      word_t pc_plus_4;
      logic  predicted;
   } fetch_t;

   typedef struct packed {
      logic        write;
      btb_idx_t    idx;
      btb_tag_t    tag;
      word_t       target;
      pred_state_t state;
   } btb_update_t;

   function automatic btb_idx_t btb_idx_of(input word_t addr);
      return addr[`FETCH_BTB_IDX_W+1:2];  // word aligned, skip byte offset
   endfunction

   function automatic btb_tag_t btb_tag_of(input word_t addr);
      return addr[`FETCH_WORD_W-1:`FETCH_BTB_IDX_W+2];
   endfunction

endpackage

`default_nettype wire

/* hdl/fetch_predict.sv */
// fetch and redirect top level
// PC, BTB with 2-bit predictors, redirect check and fetch/decode register
// flush goes out to the later stages whenever a resolve redirects fetch

`default_nettype none

module fetch_predict
   import fetch_pkg::*;
(
   input  logic     CLK,
   input  logic     nRST,
   input  logic     ihit,
   input  word_t    imemload,
   input  resolve_t resolve,
   output word_t    imemaddr,
   output fetch_t   fetch_out,
   output logic     flush
);

   btb_entry_t  lookup;
   btb_entry_t  check;
   btb_update_t update;
   logic        predict;
   word_t       predict_target;
   logic        redirect;
   word_t       redirect_addr;
   word_t       pc_plus_4;

   assign flush = redirect;

   btb u_btb (
      .CLK        (CLK),
      .nRST       (nRST),
      .fetch_pc   (imemaddr),
      .resolve_pc (resolve.pc),
      .update     (update),
      .lookup     (lookup),
      .check      (check)
   );

   redirect_control u_redirect_control (
      .fetch_pc       (imemaddr),
      .lookup         (lookup),
      .check          (check),
      .resolve        (resolve),
      .ihit           (ihit),
      .predict        (predict),
      .predict_target (predict_target),
      .redirect       (redirect),
      .redirect_addr  (redirect_addr),
      .update         (update)
   );

   program_counter u_program_counter (
      .CLK            (CLK),
      .nRST           (nRST),
      .ihit           (ihit),
      .predict        (predict),
      .predict_target (predict_target),
      .redirect       (redirect),
      .redirect_addr  (redirect_addr),
      .pc             (imemaddr),
      .pc_plus_4      (pc_plus_4)
   );

   fetch_latch u_fetch_latch (
      .CLK       (CLK),
      .nRST      (nRST),
      .ihit      (ihit),
      .flush     (redirect),
      .instr     (imemload),
      .pc_plus_4 (pc_plus_4),
      .predict   (predict),
      .fetch_out (fetch_out)
   );

endmodule

`default_nettype wire

/* hdl/fetch_settings.svh */
// fetch slice settings
// reset PC, word width and BTB index width shared by package and RTL
// BTB depth follows from the index width (2 bits -> 4 entries)

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// address and instruction width
`define FETCH_WORD_W 32

// direct mapped BTB index, taken from addr bits [IDX_W+1:2]
`define FETCH_BTB_IDX_W 2

// first fetch address after reset
`define FETCH_PC_INIT 32'h0000_0000

`endif

/* hdl/program_counter.sv */
// program counter
// next PC priority: redirect, then BTB prediction, then PC + 4
// loads on ihit, or on a redirect regardless of ihit

`default_nettype none

`include "fetch_settings.svh"

module program_counter
   import fetch_pkg::*;
(
   input  logic  CLK,
   input  logic  nRST,
   input  logic  ihit,
   input  logic  predict,
   input  word_t predict_target,
   input  logic  redirect,
   input  word_t redirect_addr,
   output word_t pc,
   output word_t pc_plus_4
);

   word_t pc_next;
   logic  pc_en;

   assign pc_plus_4 = pc + 32'd4;
   assign pc_en     = ihit || redirect; // hold while stalled

   always_comb
   begin
      if (redirect)
         pc_next = redirect_addr;  // resolve wins over fetch prediction
      else if (predict)
         pc_next = predict_target;
      else
         pc_next = pc_plus_4;
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         pc <= `FETCH_PC_INIT;
      end
      else if (pc_en)
      begin
         pc <= pc_next;
      end
   end

endmodule

`default_nettype wire

/* hdl/redirect_control.sv */
// redirect control
// predicts taken at fetch from the BTB entry of the current PC,
// checks each resolved branch or jump against the bit it was fetched with,
// picks the redirect address and forms the BTB update command
// BTB writes only for conditional branches, and only in an ihit cycle

`default_nettype none

module redirect_control
   import fetch_pkg::*;
(
   input  word_t       fetch_pc,
   input  btb_entry_t  lookup,
   input  btb_entry_t  check,
   input  resolve_t    resolve,
   input  logic        ihit,
   output logic        predict,
   output word_t       predict_target,
   output logic        redirect,
   output word_t       redirect_addr,
   output btb_update_t update
);

   btb_tag_t    res_tag;
   logic        lookup_hit;
   logic        check_hit;
   logic        false_taken;  // predicted taken, fell through
   logic        mispredict;
   pred_state_t next_state;

   // fetch side
   assign lookup_hit     = lookup.valid && (lookup.tag == btb_tag_of(fetch_pc));
   assign predict        = lookup_hit && (lookup.state inside {STRONG_TAKEN, WEAK_TAKEN});
   assign predict_target = lookup.target;

   // resolve side
   assign false_taken = resolve.cond && !resolve.taken && resolve.predicted;
   assign mispredict  = resolve.cond && (resolve.taken != resolve.predicted);
   assign redirect    = resolve.valid && (resolve.jump || mispredict);

   // fall through address only for a wrongly taken branch
   assign redirect_addr = (!resolve.jump && false_taken) ? resolve.pc + 32'd4
                                                         : resolve.target;

   // counter step, saturating both ends
   always_comb
   begin
      next_state = check.state;
      if (resolve.taken)
      begin
         case (check.state)
            STRONG_NOT: next_state = WEAK_NOT;
            WEAK_NOT:   next_state = WEAK_TAKEN;
            default:    next_state = STRONG_TAKEN;
         endcase
      end
      else
      begin
         case (check.state)
            STRONG_TAKEN: next_state = WEAK_TAKEN;
            WEAK_TAKEN:   next_state = WEAK_NOT;
            default:      next_state = STRONG_NOT;
         endcase
      end
   end

   assign res_tag   = btb_tag_of(resolve.pc);
   assign check_hit = check.valid && (check.tag == res_tag);

   // jumps never touch the BTB
   assign update.write  = resolve.valid && resolve.cond && !resolve.jump && ihit;
   assign update.idx    = btb_idx_of(resolve.pc);
   assign update.tag    = res_tag;
   assign update.target = check_hit ? check.target : resolve.target; // miss -> new target
   assign update.state  = check_hit ? next_state : STRONG_TAKEN;     // alloc strong taken

endmodule

`default_nettype wire

/* test/fetch_predict_asserts.sv */
// bound checks for the fetch and redirect slice
// reset values, flush rule, redirect target and squash,
// fetch/decode capture and back-pressure hold
// sampled at the falling edge, mid cycle

`default_nettype none

`include "fetch_settings.svh"

module fetch_predict_tb_asserts
   import fetch_pkg::*;
(
   input logic     CLK,
   input logic     nRST,
   input logic     ihit,
   input word_t    imemload,
   input resolve_t resolve,
   input word_t    imemaddr,
   input fetch_t   fetch_out,
   input logic     flush
);

   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;  // summed into the testbench report

   logic  exp_redirect;
   word_t exp_target;

   // jump, or a cond branch whose outcome differs from its fetch bit
   assign exp_redirect = resolve.valid &&
                         (resolve.jump || (resolve.cond && (resolve.taken ^ resolve.predicted)));

   // predicted taken but fell through -> back to pc + 4
   assign exp_target = (resolve.cond && resolve.predicted && !resolve.taken)
                       ? resolve.pc + 32'd4 : resolve.target;

   reset_values: assert property (@(negedge CLK)
      (!nRST && !$past(nRST)) |-> (imemaddr == `FETCH_PC_INIT && fetch_out == '0 && !flush))
   else
   begin
      $error("Mismatch at %0t: PC, fetch_out or flush wrong under reset", $time);
      fail_count++;
   end

   flush_rule: assert property (@(negedge CLK) disable iff (!nRST)
      flush == exp_redirect)
   else
   begin
      $error("Mismatch at %0t: flush %0b for this resolve", $time, flush);
      fail_count++;
   end

   // redirect wins over ihit, squashes the latch
   redirect_next: assert property (@(negedge CLK) disable iff (!nRST)
      flush |=> (imemaddr == $past(exp_target) && fetch_out == '0))
   else
   begin
      $error("Mismatch at %0t: redirect to %h or squash missed", $time, imemaddr);
      fail_count++;
   end

   capture: assert property (@(negedge CLK) disable iff (!nRST)
      (ihit && !flush) |=> (fetch_out.instr == $past(imemload) &&
                            fetch_out.pc_plus_4 == $past(imemaddr) + 32'd4))
   else
   begin
      $error("Mismatch at %0t: fetch_out did not capture instr and pc + 4", $time);
      fail_count++;
   end

   hold: assert property (@(negedge CLK) disable iff (!nRST)
      (!ihit && !flush) |=> ($stable(imemaddr) && $stable(fetch_out)))
   else
   begin
      $error("Mismatch at %0t: PC or fetch_out moved while stalled", $time);
      fail_count++;
   end

endmodule

`default_nettype wire

/* test/fetch_predict_tb.sv */
// testbench for the fetch and redirect slice
// random imemload and ihit gaps, jumps and branches fed in as resolves
// a shadow BTB gives the expected prediction and next PC of each fetch
// bound assertions cover reset, flush, redirect, capture and hold

`default_nettype none

`include "fetch_settings.svh"

module fetch_predict_tb
   import fetch_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 4;
   localparam int SEED         = 32'hcae1;
   localparam int LEN_SEQ      = 32;   // cycles per test, upper bounds
   localparam int LEN_JUMP     = 16;
   localparam int LEN_TAKEN    = 16;
   localparam int LEN_TRAIN    = 16;
   localparam int LEN_ALIAS    = 20;
   localparam int TEST_CYCLES  = LEN_SEQ + LEN_JUMP + LEN_TAKEN + LEN_TRAIN + LEN_ALIAS;
   localparam int WATCHDOG_NS  = (RESET_CYCLES + 2 * TEST_CYCLES) * CLK_PERIOD;

   localparam word_t JUMP_DEST  = 32'h0000_0200;
   localparam word_t BR_PC      = 32'h0000_0084;  // index 1
   localparam word_t BR_DEST    = 32'h0000_0400;
   localparam word_t ALIAS_PC   = 32'h0000_0184;  // index 1, other tag
   localparam word_t ALIAS_DEST = 32'h0000_0600;
   localparam word_t GATE_PC    = 32'h0000_0048;  // index 2
   localparam word_t GATE_DEST  = 32'h0000_0800;

   logic     CLK = 1'b0;
   logic     nRST;
   logic     ihit;
   word_t    imemload;
   resolve_t resolve;
   word_t    imemaddr;
   fetch_t   fetch_out;
   logic     flush;

   // shadow BTB, indexed by addr[3:2], tagged by addr[31:4]
   logic        sh_valid  [4];
   logic [27:0] sh_tag    [4];
   word_t       sh_target [4];
   pred_state_t sh_state  [4];

   logic        pend_valid = 1'b0;  // a fetch waiting for its check
   logic        pend_pred;
   word_t       pend_next;
   int unsigned errors = 0;
   int unsigned checks = 0;
   int unsigned test_num = 0;
   int unsigned tests_failed = 0;
   int unsigned errs_seen = 0;

   fetch_predict dut0 (
      .CLK       (CLK),
      .nRST      (nRST),
      .ihit      (ihit),
      .imemload  (imemload),
      .resolve   (resolve),
      .imemaddr  (imemaddr),
      .fetch_out (fetch_out),
      .flush     (flush)
   );

   bind fetch_predict fetch_predict_tb_asserts u_asserts (
      .CLK (CLK), .nRST (nRST), .ihit (ihit), .imemload (imemload),
      .resolve (resolve), .imemaddr (imemaddr), .fetch_out (fetch_out), .flush (flush)
   );

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   function automatic logic shadow_predict(input word_t addr);
      logic [1:0] i;
      i = addr[3:2];
      return sh_valid[i] && (sh_tag[i] == addr[31:4]) &&
             (sh_state[i] == STRONG_TAKEN || sh_state[i] == WEAK_TAKEN);
   endfunction

   // saturating step of the 2-bit counter
   function automatic pred_state_t step_counter(input pred_state_t s, input logic taken);
      if (taken)
         return (s == STRONG_NOT) ? WEAK_NOT : (s == WEAK_NOT) ? WEAK_TAKEN : STRONG_TAKEN;
      return (s == STRONG_TAKEN) ? WEAK_TAKEN : (s == WEAK_TAKEN) ? WEAK_NOT : STRONG_NOT;
   endfunction

   task automatic shadow_update(input resolve_t r, input logic ih);
      logic [1:0] i;
      i = r.pc[3:2];
      if (r.valid && r.cond && !r.jump && ih)  // jumps and stalled cycles write nothing
      begin
         if (sh_valid[i] && sh_tag[i] == r.pc[31:4])
            sh_state[i] = step_counter(sh_state[i], r.taken);
         else
         begin
            sh_valid[i]  = 1'b1;  // alloc, replaces an alias
            sh_tag[i]    = r.pc[31:4];
            sh_target[i] = r.target;
            sh_state[i]  = STRONG_TAKEN;
         end
      end
   endtask

   // prediction bit and next PC of the previous fetch, from the shadow
   always @(negedge CLK)
   begin
      if (pend_valid)
      begin
         checks++;
         assert (fetch_out.predicted == pend_pred && imemaddr == pend_next)
         else
         begin
            $error("Mismatch at %0t: predicted %0b next pc %h, expected %0b and %h",
                   $time, fetch_out.predicted, imemaddr, pend_pred, pend_next);
            errors++;
         end
      end
      pend_valid = nRST && ihit && !flush;
      pend_pred  = shadow_predict(imemaddr);
      pend_next  = pend_pred ? sh_target[imemaddr[3:2]] : imemaddr + 32'd4;
   end

   task automatic fetch_cycle(input logic ih);
      ihit     = ih;
      imemload = $urandom();
      @(posedge CLK);
      #1;
   endtask

   task automatic fetch_run(input int n);
      for (int k = 0; k < n; k++)
         fetch_cycle($urandom_range(3) != 0);  // about one stall in four
   endtask

   task automatic send_resolve(input resolve_t r, input logic ih);
      resolve  = r;
      ihit     = ih;
      imemload = $urandom();
      @(posedge CLK);
      shadow_update(r, ih);  // same edge as the BTB write
      #1;
      resolve = '0;
   endtask

   // predicted bit is the one the shadow gave at fetch
   function automatic resolve_t branch(input word_t pc, input word_t target, input logic taken);
      resolve_t r;
      r           = '0;
      r.valid     = 1'b1;
      r.cond      = 1'b1;
      r.taken     = taken;
      r.predicted = shadow_predict(pc);
      r.pc        = pc;
      r.target    = target;
      return r;
   endfunction

   task automatic jump_to(input word_t pc, input word_t target);
      resolve_t r;
      r           = '0;
      r.valid     = 1'b1;
      r.jump      = 1'b1;
      r.predicted = shadow_predict(pc);
      r.pc        = pc;
      r.target    = target;
      send_resolve(r, 1'b1);
      fetch_cycle(1'b1);  // fetch at the target
   endtask

   task automatic end_test(input string name);
      int unsigned total;
      total = errors + dut0.u_asserts.fail_count;
      test_num++;
      if (total != errs_seen)
         tests_failed++;
      $display("test %0d %s: %s (%0d new errors)", test_num, name,
               (total == errs_seen) ? "ok" : "failed", total - errs_seen);
      errs_seen = total;
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog: run still busy after %0d ns, stopped", WATCHDOG_NS);
      $display("TEST FAIL");
      $finish;
   end

   initial
   begin
      void'($urandom(SEED));
      nRST     = 1'b0;
      ihit     = 1'b0;
      imemload = '0;
      resolve  = '0;
      for (int i = 0; i < 4; i++)
      begin
         sh_valid[i]  = 1'b0;
         sh_tag[i]    = '0;
         sh_target[i] = '0;
         sh_state[i]  = STRONG_NOT;
      end
      repeat (RESET_CYCLES) @(posedge CLK);
      #1;
      nRST = 1'b1;

      fetch_run(LEN_SEQ - 2);
      end_test("reset and sequential fetch");

      jump_to(32'h0000_0010, JUMP_DEST);
      fetch_run(4);
      jump_to(32'h0000_0020, 32'h0000_0010);  // refetch the jump, no entry
      fetch_run(4);
      end_test("jump redirect");

      send_resolve(branch(BR_PC, BR_DEST, 1'b1), 1'b1);
      fetch_run(2);
      jump_to(32'h0000_0030, BR_PC);  // predicted taken to BR_DEST
      fetch_cycle(1'b1);
      fetch_run(4);
      send_resolve(branch(BR_PC, BR_DEST, 1'b1), 1'b1);  // predicted right, no flush
      fetch_run(2);
      end_test("first taken branch");

      send_resolve(branch(BR_PC, BR_DEST, 1'b0), 1'b1);  // strong -> weak taken
      fetch_run(2);
      send_resolve(branch(BR_PC, BR_DEST, 1'b0), 1'b1);  // weak taken -> weak not
      fetch_run(2);
      jump_to(32'h0000_0030, BR_PC);
      fetch_run(4);
      end_test("training toward not taken");

      send_resolve(branch(ALIAS_PC, ALIAS_DEST, 1'b1), 1'b1);
      fetch_run(2);
      jump_to(32'h0000_0030, BR_PC);
      fetch_run(3);
      send_resolve(branch(GATE_PC, GATE_DEST, 1'b1), 1'b0);  // stalled, no write
      fetch_run(2);
      jump_to(32'h0000_0030, GATE_PC);
      fetch_run(3);
      end_test("aliasing and gating");

      $display("tests %0d, failed %0d, shadow checks %0d, errors %0d",
               test_num, tests_failed, checks, errs_seen);
      if (errs_seen == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire
